// ==== logic/fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    // Address and instruction widths
    localparam int PC_W    = 32;
    localparam int INSTR_W = 32;

    // Bytes per instruction, also the sequential PC step
    localparam int INSTR_BYTES = INSTR_W / 8;
    localparam int BYTE_OFF_W  = $clog2(INSTR_BYTES);

    // Direct-mapped cache geometry
    localparam int IC_LINES = 16;
    localparam int IC_WORDS = 4;
    localparam int LINE_W   = IC_WORDS * INSTR_W;

    // Word select within a line
    localparam int OFF_W = $clog2(IC_WORDS);

    // Line index sits right above the word select
    localparam int IDX_W   = $clog2(IC_LINES);
    localparam int IDX_LSB = BYTE_OFF_W + OFF_W;

    // Tag is everything above the index
    localparam int TAG_LSB = IDX_LSB + IDX_W;
    localparam int TAG_W   = PC_W - TAG_LSB;

    // Fetch buffer size, doubles as the credit limit in fe_ctl
    localparam int FB_DEPTH = 4;
    localparam int FB_PTR_W = $clog2(FB_DEPTH);
    // Count must reach FB_DEPTH itself
    localparam int FB_CNT_W = $clog2(FB_DEPTH + 1);

    // PC generator states
    typedef enum logic {
        FETCHING,
        HALTED
    } t_ctl_state;

    // Cache refill FSM
    // IC_LOOKUP   normal hit path, accepts requests
    // IC_REQ      req high, waiting for ack
    // IC_RELEASE  req low, waiting for ack to fall
    typedef enum logic [1:0] {
        IC_LOOKUP,
        IC_REQ,
        IC_RELEASE
    } t_ic_state;

endpackage

`default_nettype wire

// ==== logic/fe_ctl.sv ====
`timescale 1ns/10ps
`default_nettype none

module fe_ctl (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    br_mispred_valid,
    input  logic [fe_pkg::PC_W-1:0] br_mispred_target,
    input  logic                    nuke_valid,
    input  logic [fe_pkg::PC_W-1:0] nuke_target,
    input  logic                    resume_fetch,

    input  logic                    fetch_stall,
    input  logic                    deq,

    output logic                    fetch_valid,
    output logic [fe_pkg::PC_W-1:0] fetch_pc,
    output logic                    flush
);
    import fe_pkg::*;

    t_ctl_state           state;
    t_ctl_state           state_nxt;
    logic [PC_W-1:0]      redirect_pc;
    logic [PC_W-1:0]      pc_nxt;
    logic [FB_CNT_W-1:0]  credits;
    logic [FB_CNT_W-1:0]  credits_nxt;
    logic                 has_credit;

    // Any redirect flushes the pipe behind us
    assign flush = br_mispred_valid | nuke_valid;

    // Nuke wins over a mispredict in the same cycle
    assign redirect_pc = nuke_valid ? nuke_target : br_mispred_target;

    // One credit per fetch still in flight or sitting in the buffer
    assign has_credit = credits < FB_CNT_W'(FB_DEPTH);

    // Issue rule
    // no fetch in the redirect cycle, the PC is being replaced
    assign fetch_valid = (state == FETCHING) && !fetch_stall && has_credit && !flush;

    // Next PC
    always_comb begin
        pc_nxt = fetch_pc;
        if (flush) begin
            pc_nxt = redirect_pc;
        end else if (fetch_valid) begin
            pc_nxt = fetch_pc + PC_W'(INSTR_BYTES);
        end
    end

    // Halt on nuke, leave only on resume
    always_comb begin
        state_nxt = state;
        case (state)
            FETCHING: begin
                if (nuke_valid) begin
                    state_nxt = HALTED;
                end
            end
            HALTED: begin
                // A fresh nuke keeps us parked
                if (!nuke_valid && resume_fetch) begin
                    state_nxt = FETCHING;
                end
            end
            default: begin
                state_nxt = FETCHING;
            end
        endcase
    end

    // Credit counter
    always_comb begin
        credits_nxt = credits;
        if (flush) begin
            // Everything downstream is dropped
            credits_nxt = '0;
        end else begin
            case ({fetch_valid, deq})
                2'b10:   credits_nxt = credits + 1'b1;
                2'b01:   credits_nxt = credits - 1'b1;
                default: credits_nxt = credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCHING;
            fetch_pc <= '0;
            credits  <= '0;
        end else begin
            state    <= state_nxt;
            fetch_pc <= pc_nxt;
            credits  <= credits_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache (
    input  logic                       clk,
    input  logic                       reset,

    // Request side from fe_ctl
    input  logic                       fetch_valid,
    input  logic [fe_pkg::PC_W-1:0]    fetch_pc,
    input  logic                       flush,
    output logic                       fetch_stall,

    // Write strobe into the fetch buffer
    output logic                       ic_valid,
    output logic [fe_pkg::PC_W-1:0]    ic_pc,
    output logic [fe_pkg::INSTR_W-1:0] ic_instr,

    // Four-phase refill port
    output logic                       l2_req,
    output logic [fe_pkg::PC_W-1:0]    l2_addr,
    input  logic                       l2_ack,
    input  logic [fe_pkg::LINE_W-1:0]  l2_data
);
    import fe_pkg::*;

    t_ic_state          state;
    t_ic_state          state_nxt;

    // Arrays, only the valid bits are cleared
    logic [IC_LINES-1:0] line_valid;
    logic [TAG_W-1:0]    tag_mem  [IC_LINES];
    logic [LINE_W-1:0]   data_mem [IC_LINES];

    // Lookup fields
    logic               lk_go;
    logic [IDX_W-1:0]   lk_idx;
    logic [TAG_W-1:0]   lk_tag;
    logic [OFF_W-1:0]   lk_off;
    logic [LINE_W-1:0]  lk_line;
    logic               lk_hit;

    // Miss tracking
    logic [PC_W-1:0]    miss_pc;
    logic [IDX_W-1:0]   miss_idx;
    logic [OFF_W-1:0]   miss_off;
    logic               refill_done;
    logic               drop;

    assign lk_go   = fetch_valid && (state == IC_LOOKUP);
    assign lk_idx  = fetch_pc[IDX_LSB +: IDX_W];
    assign lk_tag  = fetch_pc[TAG_LSB +: TAG_W];
    assign lk_off  = fetch_pc[BYTE_OFF_W +: OFF_W];
    assign lk_line = data_mem[lk_idx];
    assign lk_hit  = line_valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);

    assign miss_idx = miss_pc[IDX_LSB +: IDX_W];
    assign miss_off = miss_pc[BYTE_OFF_W +: OFF_W];

    // First ack-high cycle carries the line
    assign refill_done = (state == IC_REQ) && l2_ack;

    // Hold off fe_ctl for the whole handshake
    assign fetch_stall = (state != IC_LOOKUP);

    // Request and line address come straight from state and the miss PC
    assign l2_req  = (state == IC_REQ);
    assign l2_addr = {miss_pc[PC_W-1:IDX_LSB], {IDX_LSB{1'b0}}};

    always_comb begin
        state_nxt = state;
        case (state)
            IC_LOOKUP: begin
                if (lk_go && !lk_hit) begin
                    state_nxt = IC_REQ;
                end
            end
            IC_REQ: begin
                if (l2_ack) begin
                    state_nxt = IC_RELEASE;
                end
            end
            IC_RELEASE: begin
                // No new req until ack is seen low
                if (!l2_ack) begin
                    state_nxt = IC_LOOKUP;
                end
            end
            default: begin
                state_nxt = IC_LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IC_LOOKUP;
            line_valid <= '0;
            drop       <= 1'b0;
            ic_valid   <= 1'b0;
        end else begin
            state <= state_nxt;
            // Remember a redirect seen while the refill is out
            drop  <= (state == IC_REQ) && (drop || flush);
            if (refill_done) begin
                line_valid[miss_idx] <= 1'b1;
            end
            ic_valid <= (lk_go && lk_hit) || (refill_done && !drop && !flush);
        end
    end

    // Payload and array writes
    always_ff @(posedge clk) begin
        // Latched on every lookup, only matters on a miss
        if (lk_go) begin
            miss_pc <= fetch_pc;
        end
        if (refill_done) begin
            tag_mem[miss_idx]  <= miss_pc[TAG_LSB +: TAG_W];
            data_mem[miss_idx] <= l2_data;
        end
        // Word 0 of a line sits in the low bits
        if (refill_done) begin
            ic_pc    <= miss_pc;
            ic_instr <= l2_data[miss_off * INSTR_W +: INSTR_W];
        end else if (lk_go) begin
            ic_pc    <= fetch_pc;
            ic_instr <= lk_line[lk_off * INSTR_W +: INSTR_W];
        end
    end

endmodule

`default_nettype wire

// ==== logic/fe_buf.sv ====
`timescale 1ns/10ps
`default_nettype none

module fe_buf (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,

    // Writes from the cache
    input  logic                       ic_valid,
    input  logic [fe_pkg::PC_W-1:0]    ic_pc,
    input  logic [fe_pkg::INSTR_W-1:0] ic_instr,

    // Decode side
    input  logic                       decode_ready_de0,
    output logic                       deq,
    output logic                       valid_fe1,
    output logic [fe_pkg::PC_W-1:0]    pc_fe1,
    output logic [fe_pkg::INSTR_W-1:0] instr_fe1
);
    import fe_pkg::*;

    logic [PC_W-1:0]     pc_q    [FB_DEPTH];
    logic [INSTR_W-1:0]  instr_q [FB_DEPTH];
    logic [FB_PTR_W-1:0] wr_ptr;
    logic [FB_PTR_W-1:0] rd_ptr;
    logic [FB_CNT_W-1:0] count;
    logic                enq;

    // Wrap at FB_DEPTH
    function automatic logic [FB_PTR_W-1:0] ptr_inc(input logic [FB_PTR_W-1:0] ptr);
        logic [FB_PTR_W-1:0] res;
        if (ptr == FB_PTR_W'(FB_DEPTH - 1)) begin
            res = '0;
        end else begin
            res = ptr + 1'b1;
        end
        return res;
    endfunction

    // Result arriving in the flush cycle is stale
    assign enq = ic_valid && !flush;

    // Head of the queue faces decode
    assign valid_fe1 = (count != '0);
    assign pc_fe1    = pc_q[rd_ptr];
    assign instr_fe1 = instr_q[rd_ptr];

    // Also the credit return to fe_ctl
    assign deq = valid_fe1 && decode_ready_de0;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    // credits upstream keep us from ever writing over the head
    always_ff @(posedge clk) begin
        if (enq) begin
            pc_q[wr_ptr]    <= ic_pc;
            instr_q[wr_ptr] <= ic_instr;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fe.sv ====
`timescale 1ns/10ps
`default_nettype none

module fe (
    input  logic                       clk,
    input  logic                       reset,

    // L2 refill port
    output logic                       l2_req,
    output logic [fe_pkg::PC_W-1:0]    l2_addr,
    input  logic                       l2_ack,
    input  logic [fe_pkg::LINE_W-1:0]  l2_data,

    // Redirects from the back end
    input  logic                       br_mispred_valid,
    input  logic [fe_pkg::PC_W-1:0]    br_mispred_target,
    input  logic                       nuke_valid,
    input  logic [fe_pkg::PC_W-1:0]    nuke_target,
    input  logic                       resume_fetch,

    // Decode interface
    input  logic                       decode_ready_de0,
    output logic                       valid_fe1,
    output logic [fe_pkg::PC_W-1:0]    pc_fe1,
    output logic [fe_pkg::INSTR_W-1:0] instr_fe1
);
    import fe_pkg::*;

    // PC generator to cache
    logic               fetch_valid;
    logic [PC_W-1:0]    fetch_pc;
    logic               fetch_stall;
    logic               flush;

    // Cache to buffer
    logic               ic_valid;
    logic [PC_W-1:0]    ic_pc;
    logic [INSTR_W-1:0] ic_instr;

    // Credit return
    logic               deq;

    fe_ctl u_ctl (
        .clk,
        .reset,
        .br_mispred_valid,
        .br_mispred_target,
        .nuke_valid,
        .nuke_target,
        .resume_fetch,
        .fetch_stall,
        .deq,
        .fetch_valid,
        .fetch_pc,
        .flush
    );

    icache u_icache (
        .clk,
        .reset,
        .fetch_valid,
        .fetch_pc,
        .flush,
        .fetch_stall,
        .ic_valid,
        .ic_pc,
        .ic_instr,
        .l2_req,
        .l2_addr,
        .l2_ack,
        .l2_data
    );

    fe_buf u_buf (
        .clk,
        .reset,
        .flush,
        .ic_valid,
        .ic_pc,
        .ic_instr,
        .decode_ready_de0,
        .deq,
        .valid_fe1,
        .pc_fe1,
        .instr_fe1
    );

endmodule

`default_nettype wire

// ==== dv/fe_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module fe_properties (
    input logic                       clk,
    input logic                       reset,
    input logic                       l2_req,
    input logic [fe_pkg::PC_W-1:0]    l2_addr,
    input logic                       l2_ack,
    input logic                       fetch_valid,
    input logic                       flush,
    input logic                       decode_ready_de0,
    input logic                       valid_fe1,
    input logic [fe_pkg::PC_W-1:0]    pc_fe1,
    input logic [fe_pkg::INSTR_W-1:0] instr_fe1
);

    // Sticky, raised by any failing property
    logic prop_fail;
    logic fetch_seen;
    logic accept_seen;

    initial prop_fail = 1'b0;

    // First fetch and first decode handoff since reset
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_seen  <= 1'b0;
            accept_seen <= 1'b0;
        end else begin
            if (fetch_valid) begin
                fetch_seen <= 1'b1;
            end
            if (valid_fe1 && decode_ready_de0) begin
                accept_seen <= 1'b1;
            end
        end
    end

    // Quiet front end until the first fetch
    idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        !fetch_seen |-> !valid_fe1 && !l2_req)
        else begin
            $error("decode valid or L2 request seen before the first fetch");
            prop_fail = 1'b1;
        end

    // Fetch starts at the reset vector
    first_pc_zero: assert property (@(posedge clk) disable iff (reset)
        valid_fe1 && decode_ready_de0 && !accept_seen |-> pc_fe1 == '0)
        else begin
            $error("first accepted pc_fe1 is %h, not 0", $sampled(pc_fe1));
            prop_fail = 1'b1;
        end

    // Stalled head holds, unless a redirect empties the buffer
    decode_hold: assert property (@(posedge clk) disable iff (reset)
        valid_fe1 && !decode_ready_de0 && !flush
        |=> valid_fe1 && $stable(pc_fe1) && $stable(instr_fe1))
        else begin
            $error("decode outputs moved while decode was stalled");
            prop_fail = 1'b1;
        end

    // Four-phase L2 rules
    l2_addr_hold: assert property (@(posedge clk) disable iff (reset)
        l2_req && !l2_ack |=> l2_req && $stable(l2_addr))
        else begin
            $error("L2 request or address changed before ack");
            prop_fail = 1'b1;
        end

    l2_req_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(l2_req) |-> !l2_ack)
        else begin
            $error("L2 request raised while ack was still high");
            prop_fail = 1'b1;
        end

    l2_req_release: assert property (@(posedge clk) disable iff (reset)
        $rose(l2_ack) |-> ##[0:2] !l2_req)
        else begin
            $error("L2 request not released within 2 cycles of ack");
            prop_fail = 1'b1;
        end

endmodule

bind fe fe_properties u_fe_props (
    .clk              (clk),
    .reset            (reset),
    .l2_req           (l2_req),
    .l2_addr          (l2_addr),
    .l2_ack           (l2_ack),
    .fetch_valid      (fetch_valid),
    .flush            (flush),
    .decode_ready_de0 (decode_ready_de0),
    .valid_fe1        (valid_fe1),
    .pc_fe1           (pc_fe1),
    .instr_fe1        (instr_fe1)
);

`default_nettype wire

// ==== dv/fe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fe_tb;
    import fe_pkg::*;

    typedef enum logic [1:0] {
        L2_IDLE,
        L2_DELAY,
        L2_ACK
    } t_l2_phase;

    logic               clk;
    logic               reset;
    logic               l2_req;
    logic [PC_W-1:0]    l2_addr;
    logic               l2_ack;
    logic [LINE_W-1:0]  l2_data;
    logic               br_mispred_valid;
    logic [PC_W-1:0]    br_mispred_target;
    logic               nuke_valid;
    logic [PC_W-1:0]    nuke_target;
    logic               resume_fetch;
    logic               decode_ready_de0;
    logic               valid_fe1;
    logic [PC_W-1:0]    pc_fe1;
    logic [INSTR_W-1:0] instr_fe1;

    // Model and scoreboard state
    logic [31:0]        rng;
    t_l2_phase          l2_phase;
    int                 l2_wait;
    int                 ack_hold;
    int                 ack_linger;
    logic [PC_W-1:0]    exp_pc;
    logic               halted;
    int                 accept_count;

    fe u_fe (.*);

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Each word is the inverse of its own byte address
    function automatic logic [LINE_W-1:0] line_for(input logic [PC_W-1:0] addr);
        logic [LINE_W-1:0] line;
        for (int i = 0; i < LINE_W / INSTR_W; i++) begin
            line[i*INSTR_W +: INSTR_W] = ~(addr + PC_W'(i * (INSTR_W / 8)));
        end
        return line;
    endfunction

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        stop_with_failure();
    endtask

    // Drive point is 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_accepts(input int n);
        int target;
        int cycles;
        target = accept_count + n;
        cycles = 0;
        while (accept_count < target) begin
            next_cycle();
            cycles++;
            if (cycles > 400) begin
                abort_run("timed out waiting for decode to accept instructions");
            end
        end
    endtask

    task automatic wait_l2_req();
        int cycles;
        cycles = 0;
        while (!l2_req) begin
            next_cycle();
            cycles++;
            if (cycles > 50) begin
                abort_run("timed out waiting for a refill request to L2");
            end
        end
    endtask

    task automatic pulse_mispredict(input logic [PC_W-1:0] target);
        br_mispred_valid  = 1'b1;
        br_mispred_target = target;
        next_cycle();
        br_mispred_valid  = 1'b0;
    endtask

    task automatic pulse_nuke(input logic [PC_W-1:0] target);
        nuke_valid  = 1'b1;
        nuke_target = target;
        next_cycle();
        nuke_valid  = 1'b0;
    endtask

    // Random decode stalls and the L2 responder
    always @(posedge clk) begin
        #2;
        rng = lcg_next(rng);
        decode_ready_de0 = (rng[19:18] != 2'b00);
        if (reset) begin
            l2_phase = L2_IDLE;
            l2_ack   = 1'b0;
        end else begin
            case (l2_phase)
                L2_IDLE: begin
                    if (l2_req) begin
                        rng      = lcg_next(rng);
                        l2_wait  = 1 + int'(rng[23:16] % 8'd6);
                        l2_phase = L2_DELAY;
                    end
                end
                L2_DELAY: begin
                    if (!l2_req) begin
                        abort_run("L2 request dropped before ack was given");
                    end
                    l2_wait--;
                    if (l2_wait == 0) begin
                        rng        = lcg_next(rng);
                        ack_linger = int'(rng[17:16] % 2'd3);
                        l2_ack     = 1'b1;
                        l2_data    = line_for(l2_addr);
                        ack_hold   = 0;
                        l2_phase   = L2_ACK;
                    end
                end
                default: begin
                    // Hold ack until req falls, sometimes a few cycles longer
                    if (!l2_req) begin
                        if (ack_linger == 0) begin
                            l2_ack   = 1'b0;
                            l2_phase = L2_IDLE;
                        end else begin
                            ack_linger--;
                        end
                    end else begin
                        ack_hold++;
                        if (ack_hold > 4) begin
                            abort_run("L2 request stayed high long after ack");
                        end
                    end
                end
            endcase
        end
    end

    // Scoreboard sampled mid-cycle where everything has settled
    always @(negedge clk) begin
        if (reset) begin
            exp_pc       = '0;
            halted       = 1'b0;
            accept_count = 0;
        end else begin
            if (u_fe.u_fe_props.prop_fail) begin
                abort_run("a bound property check on fe failed");
            end
            // Parked after a nuke
            if (halted) begin
                assert (!valid_fe1) else report_mismatch("valid_fe1", 32'(valid_fe1), 32'd0);
            end
            if (valid_fe1 && decode_ready_de0) begin
                assert (pc_fe1 == exp_pc) else report_mismatch("pc_fe1", pc_fe1, exp_pc);
                assert (instr_fe1 == ~pc_fe1)
                    else report_mismatch("instr_fe1", instr_fe1, ~pc_fe1);
                exp_pc = exp_pc + PC_W'(INSTR_W / 8);
                accept_count++;
            end
            // Redirect applies after this cycle's handoff
            if (nuke_valid) begin
                exp_pc = nuke_target;
                halted = 1'b1;
            end else if (br_mispred_valid) begin
                exp_pc = br_mispred_target;
            end
            if (resume_fetch) begin
                halted = 1'b0;
            end
        end
    end

    initial begin
        rng               = 32'd49252;
        reset             = 1'b1;
        l2_ack            = 1'b0;
        l2_data           = '0;
        br_mispred_valid  = 1'b0;
        br_mispred_target = '0;
        nuke_valid        = 1'b0;
        nuke_target       = '0;
        resume_fetch      = 1'b0;
        decode_ready_de0  = 1'b1;
        l2_phase          = L2_IDLE;
        repeat (10) next_cycle();
        reset = 1'b0;

        // Cold misses then hits within each line
        wait_accepts(24);
        // Target inside a fetched line
        pulse_mispredict(32'h0000_0008);
        wait_accepts(6);
        // Aliases onto lines 0 and 1
        pulse_mispredict(32'h0000_0100);
        wait_accepts(6);
        // Back to an evicted line
        pulse_mispredict(32'h0000_0004);
        wait_accepts(8);
        // Second redirect lands while the refill is out
        pulse_mispredict(32'h0000_0200);
        wait_l2_req();
        pulse_mispredict(32'h0000_0010);
        wait_accepts(8);

        pulse_nuke(32'h0000_0340);
        repeat (20) next_cycle();
        resume_fetch = 1'b1;
        next_cycle();
        resume_fetch = 1'b0;
        wait_accepts(8);
        repeat (5) next_cycle();

        if (u_fe.u_fe_props.prop_fail) begin
            abort_run("a bound property check on fe failed");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/fe_pkg.sv
logic/fe_ctl.sv
logic/icache.sv
logic/fe_buf.sv
logic/fe.sv
dv/fe_properties.sv
dv/fe_tb.sv
